// File: vlog.f
design/fl_cfg_pkg.sv
design/fl_types_pkg.sv
design/fl_req_if.sv
design/fl_req_stage.sv
design/fl_mem_1r1w.sv
design/fl_list_ctrl.sv
design/fl_bp_gen.sv
design/fl_alloc_top.sv
bench/fl_alloc_tb.sv

// File: Makefile
# Verilator build and run for the free-list allocator testbench.

VERILATOR ?= verilator
TOP       ?= fl_alloc_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fl_alloc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fl_alloc_tb;
  import fl_cfg_pkg::*;

  typedef struct packed {
    int test;
    int rep;
    bit malloc;
    bit dq_vld;
    bit pick;    // Free a random earlier allocation instead of dq_adr.
    int dq_adr;
    int bp_thr;
    int bp_hys;
  } row_t;

  logic               clk;
  logic               rst_n;
  logic               malloc;
  logic               dq_vld;
  logic [BITADDR-1:0] dq_adr;
  logic [BITCNT-1:0]  bp_thr;
  logic [BITCNT-1:0]  bp_hys;
  logic               ma_vld;
  logic [BITADDR-1:0] ma_adr;
  logic               ma_bp;
  logic               alloc_err;
  logic [BITCNT-1:0]  fl_cnt;
  logic               pwrite;
  logic [BITVBNK-1:0] pwrbadr;
  logic [BITVROW-1:0] pwrradr;
  logic               ready;

  row_t   rows[$];
  int     fl_q[$];  // Free list as the DUT should hold it, head first.
  int     held[$];  // Handed out and not yet returned.
  integer seed = 32'h648b;

  int errors;
  int checks;
  int test_errors;
  int test_checks;
  int cycles;
  int limit;

  // Expected register state after the latest rising edge.
  bit m_alloc_q;
  bit m_err_q;
  bit m_free_q;
  bit m_pop_q;
  bit m_pwrite;
  bit m_bp;
  int m_free_adr;
  int m_ma_adr;
  int m_pw_adr;

  fl_alloc_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .malloc    (malloc),
    .dq_vld    (dq_vld),
    .dq_adr    (dq_adr),
    .bp_thr    (bp_thr),
    .bp_hys    (bp_hys),
    .ma_vld    (ma_vld),
    .ma_adr    (ma_adr),
    .ma_bp     (ma_bp),
    .alloc_err (alloc_err),
    .fl_cnt    (fl_cnt),
    .pwrite    (pwrite),
    .pwrbadr   (pwrbadr),
    .pwrradr   (pwrradr),
    .ready     (ready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n) begin
      cycles++;
      if (cycles > limit) begin
        $display("Timeout: the run did not end within %0d cycles after reset.", limit);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  task automatic add_row(input int test, input int rep, input bit mal, input bit dq,
                         input bit pick, input int adr, input int thr, input int hys);
    row_t r;
    r = '{test, rep, mal, dq, pick, adr, thr, hys};
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(2, 8, 1, 0, 0, 0, 16, 8);   // Back-to-back mallocs take 0 to 7.
    add_row(2, 3, 0, 0, 0, 0, 16, 8);
    add_row(3, 1, 0, 1, 0, 5, 16, 8);
    add_row(3, 1, 0, 1, 0, 2, 16, 8);
    add_row(3, 3, 0, 1, 1, 0, 16, 8);
    add_row(3, 3, 0, 0, 0, 0, 16, 8);
    add_row(3, 58, 1, 0, 0, 0, 16, 8);  // Wraps past slot 63 into the freed ones.
    add_row(3, 3, 0, 0, 0, 0, 16, 8);
    add_row(4, 5, 1, 0, 0, 0, 16, 8);   // Three left, so the last two fail.
    add_row(4, 3, 0, 0, 0, 0, 16, 8);
    add_row(4, 1, 0, 1, 1, 0, 16, 8);
    add_row(4, 3, 0, 0, 0, 0, 16, 8);
    add_row(4, 1, 1, 0, 0, 0, 16, 8);
    add_row(4, 3, 0, 0, 0, 0, 16, 8);
    add_row(5, 30, 0, 1, 1, 0, 16, 8);  // Release at 24.
    add_row(5, 3, 0, 0, 0, 0, 16, 8);
    add_row(5, 20, 1, 0, 0, 0, 16, 8);
    add_row(5, 3, 0, 0, 0, 0, 16, 8);
    add_row(5, 3, 0, 0, 0, 0, 4, 4);
    add_row(6, 4, 1, 1, 1, 0, 4, 4);
    add_row(6, 3, 0, 0, 0, 0, 4, 4);
  endtask

  function automatic int table_cycles();
    int n;
    n = 0;
    foreach (rows[i]) begin
      n += rows[i].rep;
    end
    return n;
  endfunction

  function automatic string test_title(input int test);
    case (test)
      1:       return "init sweep";
      2:       return "back-to-back malloc";
      3:       return "free and wrap";
      4:       return "drain and alloc_err";
      5:       return "back-pressure hysteresis";
      default: return "malloc with dequeue";
    endcase
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    checks++;
    test_checks++;
    assert (got == exp) else begin
      $display("[ERROR] %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input int test);
    if (test_errors == 0) begin
      $display("Test %0d, %s: passed, %0d checks.", test, test_title(test), test_checks);
    end else begin
      $display("Test %0d, %s: failed, %0d of %0d checks wrong.", test, test_title(test),
               test_errors, test_checks);
    end
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic take_listed(input int adr);
    int idx[$];
    idx = held.find_first_index(x) with (x == adr);
    if (idx.size() == 0) begin
      $display("Table frees address %0d, which is not allocated.", adr);
      errors++;
      test_errors++;
    end else begin
      held.delete(idx[0]);
    end
  endtask

  task automatic take_random(output int adr);
    int idx;
    adr = 0;
    if (held.size() == 0) begin
      $display("Table frees an address, but none is allocated.");
      errors++;
      test_errors++;
    end else begin
      idx = $unsigned($random(seed)) % held.size();
      adr = held[idx];
      held.delete(idx);
    end
  endtask

  task automatic check_outputs();
    check_val("ready", int'(ready), 1);
    check_val("fl_cnt", int'(fl_cnt), fl_q.size());
    check_val("alloc_err", int'(alloc_err), int'(m_err_q));
    check_val("ma_vld", int'(ma_vld), int'(m_pop_q));
    check_val("ma_bp", int'(ma_bp), int'(m_bp));
    check_val("pwrite", int'(pwrite), int'(m_pwrite));
    if (m_pop_q) begin
      check_val("ma_adr", int'(ma_adr), m_ma_adr);
      held.push_back(m_ma_adr);
    end
    if (m_pwrite) begin
      check_val("pwrbadr", int'(pwrbadr), m_pw_adr / NUMVROW);
      check_val("pwrradr", int'(pwrradr), m_pw_adr % NUMVROW);
    end
  endtask

  // Advances the expected state across one rising edge with the given inputs.
  task automatic step_model(input bit req_alloc, input bit req_free, input int adr,
                            input int thr, input int hys);
    bit empty;
    empty = fl_q.size() <= int'(m_alloc_q);  // A pop in flight is not yet counted.
    if (fl_q.size() < thr) begin
      m_bp = 1'b1;
    end else if (fl_q.size() >= thr + hys) begin
      m_bp = 1'b0;
    end
    m_pwrite = m_free_q;
    if (m_free_q) begin
      m_pw_adr = m_free_adr;
    end
    m_pop_q = m_alloc_q;
    if (m_alloc_q) begin
      m_ma_adr = fl_q.pop_front();
    end
    if (m_free_q) begin
      fl_q.push_back(m_free_adr);
    end
    m_alloc_q = req_alloc && !empty;
    m_err_q   = req_alloc && empty;
    m_free_q  = req_free;
    if (req_free) begin
      m_free_adr = adr;
    end
  endtask

  initial begin : main
    int   cur_test;
    int   adr;
    int   wait_cycles;
    row_t r;
    clk    = 1'b0;
    rst_n  = 1'b0;
    malloc = 1'b0;
    dq_vld = 1'b0;
    dq_adr = '0;
    bp_thr = BITCNT'(16);
    bp_hys = BITCNT'(8);
    errors = 0;
    checks = 0;
    test_errors = 0;
    test_checks = 0;
    cycles = 0;
    wait_cycles = 0;
    build_table();
    limit = NUMADDR + table_cycles() + 50;
    for (int i = 0; i < NUMADDR; i++) begin
      fl_q.push_back(i);
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!ready);
    check_val("ready delay", wait_cycles, NUMADDR + 1);
    check_val("fl_cnt", int'(fl_cnt), NUMADDR);
    check_val("ma_bp", int'(ma_bp), 0);
    report_test(1);

    cur_test = rows[0].test;
    foreach (rows[i]) begin
      r = rows[i];
      for (int k = 0; k < r.rep; k++) begin
        @(negedge clk);
        check_outputs();
        if (r.test != cur_test) begin
          report_test(cur_test);
          cur_test = r.test;
        end
        adr = r.dq_adr;
        if (r.dq_vld && r.pick) begin
          take_random(adr);
        end else if (r.dq_vld) begin
          take_listed(adr);
        end
        malloc = r.malloc;
        dq_vld = r.dq_vld;
        dq_adr = BITADDR'(adr);
        bp_thr = BITCNT'(r.bp_thr);
        bp_hys = BITCNT'(r.bp_hys);
        step_model(r.malloc, r.dq_vld, adr, r.bp_thr, r.bp_hys);
      end
    end
    @(negedge clk);
    check_outputs();
    report_test(cur_test);

    $display("Summary: %0d checks, %0d wrong.", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/fl_alloc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fl_alloc_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           malloc,
  input  logic                           dq_vld,
  input  logic [fl_cfg_pkg::BITADDR-1:0] dq_adr,
  input  logic [fl_cfg_pkg::BITCNT-1:0]  bp_thr,
  input  logic [fl_cfg_pkg::BITCNT-1:0]  bp_hys,
  output logic                           ma_vld,
  output logic [fl_cfg_pkg::BITADDR-1:0] ma_adr,
  output logic                           ma_bp,
  output logic                           alloc_err,
  output logic [fl_cfg_pkg::BITCNT-1:0]  fl_cnt,
  output logic                           pwrite,
  output logic [fl_cfg_pkg::BITVBNK-1:0] pwrbadr,
  output logic [fl_cfg_pkg::BITVROW-1:0] pwrradr,
  output logic                           ready
);
  import fl_cfg_pkg::*;
  import fl_types_pkg::*;

  fl_req_if req_bus ();

  logic               mem_wr;
  logic [BITADDR-1:0] mem_wr_adr;
  logic [BITADDR-1:0] mem_wr_din;
  logic               mem_rd;
  logic [BITADDR-1:0] mem_rd_adr;
  logic [BITADDR-1:0] mem_rd_dout;
  fl_addr_u           ma_adr_u;
  logic               push_vld;
  fl_addr_u           push_adr;

  assign ma_adr = ma_adr_u.flat;
  assign ready  = req_bus.ready;

  fl_req_stage u_req_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .malloc    (malloc),
    .dq_vld    (dq_vld),
    .dq_adr    (dq_adr),
    .cnt       (fl_cnt),
    .alloc_err (alloc_err),
    .req       (req_bus.stage)
  );

  fl_list_ctrl u_list_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req_bus.ctrl),
    .wr      (mem_wr),
    .wr_adr  (mem_wr_adr),
    .wr_din  (mem_wr_din),
    .rd      (mem_rd),
    .rd_adr  (mem_rd_adr),
    .rd_dout (mem_rd_dout),
    .ma_vld  (ma_vld),
    .ma_adr  (ma_adr_u),
    .cnt     (fl_cnt),
    .pwrite  (push_vld),
    .pw_adr  (push_adr)
  );

  fl_mem_1r1w u_mem (
    .clk     (clk),
    .wr      (mem_wr),
    .wr_adr  (mem_wr_adr),
    .wr_din  (mem_wr_din),
    .rd      (mem_rd),
    .rd_adr  (mem_rd_adr),
    .rd_dout (mem_rd_dout)
  );

  fl_bp_gen u_bp_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .cnt       (fl_cnt),
    .bp_thr    (bp_thr),
    .bp_hys    (bp_hys),
    .pwrite_in (push_vld),
    .pw_adr    (push_adr),
    .ma_bp     (ma_bp),
    .pwrite    (pwrite),
    .pwrbadr   (pwrbadr),
    .pwrradr   (pwrradr)
  );

endmodule

`default_nettype wire

// File: design/fl_bp_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fl_bp_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [fl_cfg_pkg::BITCNT-1:0]  cnt,
  input  logic [fl_cfg_pkg::BITCNT-1:0]  bp_thr,
  input  logic [fl_cfg_pkg::BITCNT-1:0]  bp_hys,
  input  logic                           pwrite_in,
  input  fl_types_pkg::fl_addr_u         pw_adr,
  output logic                           ma_bp,
  output logic                           pwrite,
  output logic [fl_cfg_pkg::BITVBNK-1:0] pwrbadr,
  output logic [fl_cfg_pkg::BITVROW-1:0] pwrradr
);
  import fl_cfg_pkg::*;

  logic [BITCNT:0] release_lvl;
  logic            bp_set;
  logic            bp_clr;

  assign release_lvl = {1'b0, bp_thr} + {1'b0, bp_hys};  // Carry bit kept for large settings.
  assign bp_set      = cnt < bp_thr;
  assign bp_clr      = {1'b0, cnt} >= release_lvl;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ma_bp  <= 1'b0;
      pwrite <= 1'b0;
    end else begin
      // Between the two levels the previous state holds.
      if (bp_set) begin
        ma_bp <= 1'b1;
      end else if (bp_clr) begin
        ma_bp <= 1'b0;
      end
      pwrite <= pwrite_in;
    end
  end

  // The freed address goes out split as bank and row.
  always_ff @(posedge clk) begin
    if (pwrite_in) begin
      pwrbadr <= pw_adr.bank_row.bank;
      pwrradr <= pw_adr.bank_row.row;
    end
  end

  // Once the count reaches the release level, back-pressure is gone on the next cycle.
  a_bp_release : assert property (
    @(posedge clk) disable iff (!rst_n)
    ({1'b0, cnt} >= ({1'b0, bp_thr} + {1'b0, bp_hys})) |=> !ma_bp
  );

endmodule

`default_nettype wire

// File: design/fl_list_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fl_list_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  fl_req_if.ctrl                         req,
  output logic                           wr,
  output logic [fl_cfg_pkg::BITADDR-1:0] wr_adr,
  output logic [fl_cfg_pkg::BITADDR-1:0] wr_din,
  output logic                           rd,
  output logic [fl_cfg_pkg::BITADDR-1:0] rd_adr,
  input  logic [fl_cfg_pkg::BITADDR-1:0] rd_dout,
  output logic                           ma_vld,
  output fl_types_pkg::fl_addr_u         ma_adr,
  output logic [fl_cfg_pkg::BITCNT-1:0]  cnt,
  output logic                           pwrite,
  output fl_types_pkg::fl_addr_u         pw_adr
);
  import fl_cfg_pkg::*;
  import fl_types_pkg::*;

  logic               ready_q;
  logic [BITCNT-1:0]  sweep;
  logic               sweep_wr;
  logic [BITADDR-1:0] head;
  logic [BITADDR-1:0] tail;
  logic [BITCNT-1:0]  cnt_q;
  logic               pop_q;

  function automatic logic [BITADDR-1:0] ptr_inc(input logic [BITADDR-1:0] ptr);
    logic [BITADDR-1:0] nxt;
    if (ptr == BITADDR'(NUMADDR - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // The sweep writes address i to slot i, one slot per cycle.
  assign sweep_wr = !ready_q && (sweep != BITCNT'(NUMADDR));

  assign req.ready = ready_q;

  // Pushes only arrive after ready, so they never compete with the sweep.
  assign wr     = sweep_wr || req.free_vld;
  assign wr_adr = sweep_wr ? sweep[BITADDR-1:0] : tail;
  assign wr_din = sweep_wr ? sweep[BITADDR-1:0] : req.free_adr.flat;

  assign rd     = req.alloc;
  assign rd_adr = head;

  // The popped address leaves the memory one cycle after the read is issued.
  assign ma_vld      = pop_q;
  assign ma_adr.flat = rd_dout;

  assign cnt = cnt_q;

  assign pwrite = req.free_vld;
  assign pw_adr = req.free_adr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
      sweep   <= '0;
      head    <= '0;
      tail    <= '0;
      cnt_q   <= BITCNT'(NUMADDR);  // Every address is free, the sweep only writes them down.
      pop_q   <= 1'b0;
    end else begin
      if (!ready_q) begin
        if (sweep_wr) begin
          sweep <= sweep + 1'b1;
        end else begin
          ready_q <= 1'b1;
        end
      end

      pop_q <= req.alloc;

      if (req.alloc) begin
        head <= ptr_inc(head);
      end
      if (req.free_vld) begin
        tail <= ptr_inc(tail);  // After a full sweep the tail has wrapped back onto the head.
      end

      case ({req.alloc, req.free_vld})
        2'b10:   cnt_q <= cnt_q - 1'b1;
        2'b01:   cnt_q <= cnt_q + 1'b1;
        default: cnt_q <= cnt_q;  // A pop and a push together cancel out.
      endcase
    end
  end

  // The request stage must have refused a malloc that finds the list empty.
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    req.alloc |-> (cnt_q != '0)
  );

  // Frees beyond the buffer size mean an address was returned twice.
  a_cnt_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= BITCNT'(NUMADDR)
  );

endmodule

`default_nettype wire

// File: design/fl_mem_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module fl_mem_1r1w (
  input  logic                           clk,
  input  logic                           wr,
  input  logic [fl_cfg_pkg::BITADDR-1:0] wr_adr,
  input  logic [fl_cfg_pkg::BITADDR-1:0] wr_din,
  input  logic                           rd,
  input  logic [fl_cfg_pkg::BITADDR-1:0] rd_adr,
  output logic [fl_cfg_pkg::BITADDR-1:0] rd_dout
);
  import fl_cfg_pkg::*;

  logic [BITADDR-1:0] mem [NUMADDR];

  // Registered read. A write to the same slot in the same cycle is seen on the next read only.
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_adr] <= wr_din;
    end
    if (rd) begin
      rd_dout <= mem[rd_adr];
    end
  end

  // Head and tail only meet on an empty or a full list. The request stage never pops
  // an empty list and a full list has nothing left to free.
  a_no_rw_collision : assert property (
    @(posedge clk)
    (rd && wr) |-> (rd_adr != wr_adr)
  );

endmodule

`default_nettype wire

// File: design/fl_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fl_req_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          malloc,
  input  logic                          dq_vld,
  input  logic [fl_cfg_pkg::BITADDR-1:0] dq_adr,
  input  logic [fl_cfg_pkg::BITCNT-1:0]  cnt,
  output logic                          alloc_err,
  fl_req_if.stage                       req
);
  import fl_cfg_pkg::*;
  import fl_types_pkg::*;

  logic     alloc_q;
  logic     free_vld_q;
  fl_addr_u free_adr_q;
  logic     empty;

  // A pop registered last cycle has not reached the count yet, so it still
  // holds one of the counted addresses.
  assign empty = cnt <= BITCNT'(alloc_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alloc_q    <= 1'b0;
      free_vld_q <= 1'b0;
      alloc_err  <= 1'b0;
    end else begin
      // Nothing is accepted before the list has been swept.
      alloc_q    <= malloc && req.ready && !empty;
      alloc_err  <= malloc && req.ready && empty;
      free_vld_q <= dq_vld && req.ready;
    end
  end

  always_ff @(posedge clk) begin
    if (dq_vld) begin
      free_adr_q.flat <= dq_adr;
    end
  end

  assign req.alloc    = alloc_q;
  assign req.free_vld = free_vld_q;
  assign req.free_adr = free_adr_q;

  // A malloc either gets an address or an error, never both.
  a_alloc_xor_err : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(alloc_q && alloc_err)
  );

endmodule

`default_nettype wire

// File: design/fl_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Registered request strobes from the input stage and ready back from the list controller.
interface fl_req_if ();
  import fl_types_pkg::*;

  logic     alloc;     // One pop per cycle.
  logic     free_vld;  // One push per cycle.
  fl_addr_u free_adr;
  logic     ready;     // High once the init sweep has filled the list.

  modport stage (
    output alloc,
    output free_vld,
    output free_adr,
    input  ready
  );

  modport ctrl (
    input  alloc,
    input  free_vld,
    input  free_adr,
    output ready
  );

endinterface

`default_nettype wire

// File: design/fl_types_pkg.sv
`default_nettype none

package fl_types_pkg;

  // Bank in the upper bits, row in the lower bits.
  typedef struct packed {
    logic [fl_cfg_pkg::BITVBNK-1:0] bank;
    logic [fl_cfg_pkg::BITVROW-1:0] row;
  } fl_bank_row_s;

  // A buffer address. The free list stores and hands out the flat word,
  // and the write port toward the banks decodes the same bits as bank and row.
  typedef union packed {
    logic [fl_cfg_pkg::BITADDR-1:0] flat;
    fl_bank_row_s                   bank_row;
  } fl_addr_u;

endpackage

`default_nettype wire

// File: design/fl_cfg_pkg.sv
`default_nettype none

package fl_cfg_pkg;

  // The buffer is organized as banks of rows.
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  localparam int NUMADDR = NUMVBNK * NUMVROW;  // Every buffer address is one bank and row pair.
  localparam int BITADDR = BITVBNK + BITVROW;

  // The free count has to reach NUMADDR itself, so it takes one more bit than the address.
  localparam int BITCNT = $clog2(NUMADDR + 1);

endpackage

`default_nettype wire
